// File: dv/sys_unit_tests.txt
// instr    pc       rs1_data rd_wen rd_data  next_pc
// Expected values follow the CSR rules, starting from all CSRs zero
305110F3 00001000 80000100 1 00000000 00001004
305112F3 00001004 80000200 1 80000100 00001008
34111073 00001008 00002468 0 00000000 0000100C
341110F3 0000100C 00001234 1 00002468 00001010
342110F3 00001010 0000000F 1 00000000 00001014
342120F3 00001014 00000030 1 0000000F 00001018
342130F3 00001018 00000005 1 0000003F 0000101C
342020F3 0000101C FFFFFFFF 1 0000003A 00001020
342030F3 00001020 FFFFFFFF 1 0000003A 00001024
300460F3 00001024 DEADBEEF 1 00000000 00001028
3002E0F3 00001028 DEADBEEF 1 00000008 0000102C
3002F0F3 0000102C DEADBEEF 1 0000000D 00001030
300070F3 00001030 FFFFFFFF 1 00000008 00001034
342FD0F3 00001034 00000000 1 0000003A 00001038
F11020F3 00001038 00000000 1 53595355 0000103C
F11110F3 0000103C 12345678 1 53595355 00001040
F11020F3 00001040 00000000 1 53595355 00001044
F12110F3 00001044 FFFFFFFF 1 00000021 00001048
F12020F3 00001048 00000000 1 00000021 0000104C
7C0110F3 0000104C CAFEF00D 1 00000000 00001050
7C0020F3 00001050 00000000 1 00000000 00001054
342020F3 00001054 00000000 1 0000001F 00001058
// ecall with MIE set, then reads of mepc, mcause and mstatus
00000073 00001058 00000000 0 00000000 80000200
341020F3 80000200 00000000 1 00001058 80000204
342020F3 80000204 00000000 1 0000000B 80000208
300020F3 80000208 00000000 1 00000080 8000020C
341110F3 8000020C 0000105C 1 00001058 80000210
30200073 80000210 00000000 0 00000000 0000105C
300020F3 0000105C 00000000 1 00000088 00001060
300130F3 00001060 00000080 1 00000088 00001064
30200073 00001064 00000000 0 00000000 0000105C
300022F3 0000105C 00000000 1 00000080 00001060
00000073 00001060 00000000 0 00000000 80000200
300020F3 80000200 00000000 1 00000000 80000204
341020F3 80000204 00000000 1 00001060 80000208

// File: list.f
+incdir+design
design/sys_pkg.sv
design/dec_if.sv
design/csr_if.sv
design/sys_decode.sv
design/sys_exec.sv
design/sys_csr_file.sv
design/sys_unit.sv
dv/sys_unit_props.sv
dv/sys_unit_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module sys_unit_tb -o sim_sys_unit

out=$(./obj_dir/sim_sys_unit +verilator+error+limit+1000 2>&1) || true
echo "$out"

if echo "$out" | grep -q -x -F ">>> PASS"; then
  exit 0
fi
exit 1

// File: dv/sys_unit_tb.sv
`timescale 1ns/1ps

module sys_unit_tb;
  import sys_pkg::*;

  localparam int MAX_VECTORS = 64;
  localparam int FIELDS      = 6;  // instr, pc, rs1_data, rd_wen, rd_data, next_pc

  logic     clock;
  logic     reset;
  logic     in_valid;
  word_t    instr;
  word_t    pc;
  word_t    rs1_data;
  logic     out_valid;
  logic     rd_wen;
  reg_idx_t rd;
  word_t    rd_data;
  word_t    next_pc;

  word_t vectors [0:FIELDS*MAX_VECTORS-1];
  int    num_vectors;
  int    pending [$];        // Vector indices whose result is still due
  int    out_idx;
  int    mismatch_count;
  int    handshake_count;
  int    setup_errors;
  int    cycle_limit;
  int    cycle_count;
  logic  strobe_seen;        // in_valid at the previous falling edge

  sys_unit DUT (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (in_valid),
    .instr     (instr),
    .pc        (pc),
    .rs1_data  (rs1_data),
    .out_valid (out_valid),
    .rd_wen    (rd_wen),
    .rd        (rd),
    .rd_data   (rd_data),
    .next_pc   (next_pc)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      mismatch_count++;
      $display("MISMATCH at time %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      mismatch_count++;
      $display("MISMATCH at time %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_idx(input reg_idx_t got, input reg_idx_t exp, input string what);
    if (got !== exp) begin
      mismatch_count++;
      $display("MISMATCH at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic compare_result(input int idx);
    word_t    v_instr;
    reg_idx_t exp_rd;
    v_instr = vectors[FIELDS*idx];
    exp_rd  = v_instr[11:7];  // rd field of the instruction
    check_bit(rd_wen, vectors[FIELDS*idx+3][0], $sformatf("vector %0d rd_wen", idx));
    check_idx(rd, exp_rd, $sformatf("vector %0d rd", idx));
    check_word(rd_data, vectors[FIELDS*idx+4], $sformatf("vector %0d rd_data", idx));
    check_word(next_pc, vectors[FIELDS*idx+5], $sformatf("vector %0d next_pc", idx));
  endtask

  // Outputs are sampled half a cycle after the edge that updates them
  always @(negedge clock) begin
    if (out_valid !== strobe_seen) begin
      handshake_count++;
      if (strobe_seen) begin
        $display("Error at time %0t: out_valid missing in the cycle after a strobe", $time);
      end else begin
        $display("Error at time %0t: out_valid high without a strobe before it", $time);
      end
    end
    if (rd_wen === 1'b1 && out_valid !== 1'b1) begin
      handshake_count++;
      $display("Error at time %0t: rd_wen high while out_valid is low", $time);
    end
    if (strobe_seen && pending.size() > 0) begin
      out_idx = pending.pop_front();
      if (out_valid === 1'b1) begin
        compare_result(out_idx);
      end
    end
    strobe_seen = in_valid;
  end

  initial begin
    int gap;
    reset    <= 1'b1;
    in_valid <= 1'b0;
    instr    <= '0;
    pc       <= '0;
    rs1_data <= '0;
    mismatch_count  = 0;
    handshake_count = 0;
    setup_errors    = 0;
    strobe_seen     = 1'b0;
    num_vectors     = 0;
    void'($urandom(32'h7758_d107));
    for (int i = 0; i < FIELDS*MAX_VECTORS; i++) begin
      vectors[i] = '1;  // All ones marks the end of the loaded vectors
    end
    $readmemh("dv/sys_unit_tests.txt", vectors);
    while (num_vectors < MAX_VECTORS && vectors[FIELDS*num_vectors] !== '1) begin
      num_vectors++;
    end
    if (num_vectors == 0) begin
      setup_errors++;
      $display("Error: no vectors could be read from dv/sys_unit_tests.txt");
    end
    cycle_limit = 16 + 5*num_vectors + 50;

    repeat (16) @(posedge clock);
    reset <= 1'b0;

    for (int i = 0; i < num_vectors; i++) begin
      // IDs and unimplemented addresses go back to back
      if (i >= 14 && i <= 21) begin
        gap = 0;
      end else begin
        gap = $urandom % 4;
      end
      repeat (gap) begin
        @(posedge clock);
        in_valid <= 1'b0;
      end
      @(posedge clock);
      in_valid <= 1'b1;
      instr    <= vectors[FIELDS*i];
      pc       <= vectors[FIELDS*i+1];
      rs1_data <= vectors[FIELDS*i+2];
      pending.push_back(i);
    end
    @(posedge clock);
    in_valid <= 1'b0;

    while (pending.size() > 0) begin
      @(posedge clock);
    end
    repeat (2) @(posedge clock);  // Room to catch a late spurious out_valid

    $display("Errors: %0d value mismatches, %0d handshake errors, %0d setup errors",
             mismatch_count, handshake_count, setup_errors);
    if (mismatch_count == 0 && handshake_count == 0 && setup_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    cycle_count = 0;
    while (cycle_limit == 0 || cycle_count < cycle_limit) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("Error: timeout after %0d cycles with results still outstanding", cycle_count);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// File: dv/sys_unit_props.sv
`timescale 1ns/1ps

module sys_unit_props (
  input logic clock,
  input logic reset,
  input logic in_valid,
  input logic out_valid,
  input logic rd_wen
);

  // Each strobe gives one result exactly one cycle later
  a_valid_follows: assert property (
    @(posedge clock) disable iff (reset)
    !$past(reset) |-> (out_valid == $past(in_valid))
  ) else $error("out_valid does not follow in_valid by one cycle");

  a_wen_needs_valid: assert property (
    @(posedge clock) rd_wen |-> out_valid
  ) else $error("rd_wen is high without out_valid");

  a_quiet_in_reset: assert property (
    @(posedge clock) $past(reset) |-> (!out_valid && !rd_wen)
  ) else $error("an output is valid right after a reset cycle");

endmodule

bind sys_unit sys_unit_props u_props (
  .clock     (clock),
  .reset     (reset),
  .in_valid  (in_valid),
  .out_valid (out_valid),
  .rd_wen    (rd_wen)
);

// File: design/sys_unit.sv
`timescale 1ns/1ps

module sys_unit (
  input  logic                clock,
  input  logic                reset,
  input  logic                in_valid,
  input  sys_pkg::word_t      instr,
  input  sys_pkg::word_t      pc,
  input  sys_pkg::word_t      rs1_data,
  output logic                out_valid,
  output logic                rd_wen,
  output sys_pkg::reg_idx_t   rd,
  output sys_pkg::word_t      rd_data,
  output sys_pkg::word_t      next_pc
);

  dec_if dec_bus ();
  csr_if csr_bus ();

  sys_decode u_decode (
    .instr (instr),
    .dec   (dec_bus)
  );

  // Registers the result one cycle after the strobe
  sys_exec u_exec (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (in_valid),
    .pc        (pc),
    .rs1_data  (rs1_data),
    .dec       (dec_bus),
    .csr       (csr_bus),
    .out_valid (out_valid),
    .rd_wen    (rd_wen),
    .rd        (rd),
    .rd_data   (rd_data),
    .next_pc   (next_pc)
  );

  sys_csr_file u_csr_file (
    .clock (clock),
    .reset (reset),
    .csr   (csr_bus)
  );

endmodule

// File: design/sys_csr_file.sv
`timescale 1ns/1ps
`include "sys_macros.svh"

module sys_csr_file (
  input logic        clock,
  input logic        reset,
  csr_if.responder   csr
);
  import sys_pkg::*;

  word_t mstatus;
  word_t mcause;
  word_t mepc;
  word_t mtvec;

  // IDs are constants and unknown addresses read as zero
  always_comb begin
    case (csr.addr)
      `SYS_CSR_MSTATUS:   csr.rdata = mstatus;
      `SYS_CSR_MCAUSE:    csr.rdata = mcause;
      `SYS_CSR_MEPC:      csr.rdata = mepc;
      `SYS_CSR_MTVEC:     csr.rdata = mtvec;
      `SYS_CSR_MVENDORID: csr.rdata = `SYS_MVENDORID_VAL;
      `SYS_CSR_MARCHID:   csr.rdata = `SYS_MARCHID_VAL;
      default:            csr.rdata = '0;
    endcase
  end

  assign csr.mtvec = mtvec;
  assign csr.mepc  = mepc;

  always_ff @(posedge clock) begin
    if (reset) begin
      mstatus <= '0;
      mcause  <= '0;
      mepc    <= '0;
      mtvec   <= '0;
    end else begin
      if (csr.wen) begin
        case (csr.addr)
          `SYS_CSR_MSTATUS: mstatus <= csr.wdata;
          `SYS_CSR_MCAUSE:  mcause  <= csr.wdata;
          `SYS_CSR_MEPC:    mepc    <= csr.wdata;
          `SYS_CSR_MTVEC:   mtvec   <= csr.wdata;
          default:          ;  // Read-only or unimplemented
        endcase
      end

      // Trap entry saves the interrupt enable and masks interrupts
      if (csr.ecall) begin
        mcause <= `SYS_CAUSE_ECALL_M;
        mepc   <= csr.pc;
        mstatus[`SYS_MSTATUS_MPIE_IDX] <= mstatus[`SYS_MSTATUS_MIE_IDX];
        mstatus[`SYS_MSTATUS_MIE_IDX]  <= 1'b0;
      end

      if (csr.mret) begin
        mstatus[`SYS_MSTATUS_MIE_IDX]  <= mstatus[`SYS_MSTATUS_MPIE_IDX];
        mstatus[`SYS_MSTATUS_MPIE_IDX] <= 1'b1;
      end
    end
  end

endmodule

// File: design/sys_exec.sv
`timescale 1ns/1ps
`include "sys_macros.svh"

module sys_exec (
  input  logic                clock,
  input  logic                reset,
  input  logic                in_valid,
  input  sys_pkg::word_t      pc,
  input  sys_pkg::word_t      rs1_data,
  dec_if.consumer             dec,
  csr_if.requester            csr,
  output logic                out_valid,
  output logic                rd_wen,
  output sys_pkg::reg_idx_t   rd,
  output sys_pkg::word_t      rd_data,
  output sys_pkg::word_t      next_pc
);
  import sys_pkg::*;

  localparam csr_fn_t FN_WRITE = 2'd1;
  localparam csr_fn_t FN_SET   = 2'd2;
  localparam csr_fn_t FN_CLEAR = 2'd3;

  word_t src;
  word_t wdata;
  logic  write_ok;
  word_t next_pc_d;

  assign src = dec.use_imm ? {{(`SYS_XLEN-5){1'b0}}, dec.uimm} : rs1_data;

  always_comb begin
    case (dec.fn)
      FN_SET:   wdata = csr.rdata | src;
      FN_CLEAR: wdata = csr.rdata & ~src;
      default:  wdata = src;
    endcase
  end

  // Set and clear with a zero source are pure reads
  assign write_ok = (dec.fn == FN_WRITE) || !dec.src_zero;

  assign csr.wen   = in_valid && dec.csr_op && write_ok;
  assign csr.ecall = in_valid && dec.ecall;
  assign csr.mret  = in_valid && dec.mret;
  assign csr.addr  = dec.addr;
  assign csr.wdata = wdata;
  assign csr.pc    = pc;

  // mtvec and mepc are sampled before the CSR file commits the trap
  always_comb begin
    if (dec.ecall) begin
      next_pc_d = csr.mtvec;
    end else if (dec.mret) begin
      next_pc_d = csr.mepc;
    end else begin
      next_pc_d = pc + word_t'(4);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid <= 1'b0;
      rd_wen    <= 1'b0;
    end else begin
      out_valid <= in_valid;
      rd_wen    <= in_valid && dec.csr_op && (dec.rd != '0);
    end
  end

  always_ff @(posedge clock) begin
    if (in_valid) begin
      rd      <= dec.rd;
      rd_data <= csr.rdata;  // Old CSR value
      next_pc <= next_pc_d;
    end
  end

endmodule

// File: design/sys_decode.sv
`timescale 1ns/1ps

module sys_decode (
  input sys_pkg::word_t instr,
  dec_if.producer       dec
);
  import sys_pkg::*;

  localparam logic [6:0] OPC_SYSTEM = 7'b111_0011;
  localparam word_t      INSTR_ECALL = 32'h0000_0073;
  localparam word_t      INSTR_MRET  = 32'h3020_0073;

  logic       is_system;
  logic [2:0] funct3;
  reg_idx_t   rs1_field;

  assign is_system = (instr[6:0] == OPC_SYSTEM);
  assign funct3    = instr[14:12];
  assign rs1_field = instr[19:15];

  // funct3 of 000 is the privileged group and 100 is reserved
  always_comb begin
    dec.csr_op = 1'b0;
    if (is_system) begin
      case (funct3)
        3'b001, 3'b010, 3'b011,
        3'b101, 3'b110, 3'b111: dec.csr_op = 1'b1;
        default:                dec.csr_op = 1'b0;
      endcase
    end
  end

  assign dec.fn      = funct3[1:0];
  assign dec.use_imm = funct3[2];

  // The immediate forms reuse the rs1 field for uimm
  assign dec.uimm     = rs1_field;
  assign dec.src_zero = (rs1_field == '0);

  assign dec.addr = instr[31:20];
  assign dec.rd   = instr[11:7];

  // Only the exact encodings count as traps
  assign dec.ecall = (instr == INSTR_ECALL);
  assign dec.mret  = (instr == INSTR_MRET);

endmodule

// File: design/csr_if.sv
`timescale 1ns/1ps

interface csr_if;
  import sys_pkg::*;

  logic      wen;   // Already gated by the input strobe
  logic      ecall;
  logic      mret;
  csr_addr_t addr;
  word_t     wdata;
  word_t     pc;    // Becomes mepc on ecall

  // Combinational from the CSR state, so they show the old values
  word_t     rdata;
  word_t     mtvec;
  word_t     mepc;

  modport requester (
    output wen, ecall, mret, addr, wdata, pc,
    input  rdata, mtvec, mepc
  );

  modport responder (
    input  wen, ecall, mret, addr, wdata, pc,
    output rdata, mtvec, mepc
  );

endinterface

// File: design/dec_if.sv
`timescale 1ns/1ps

interface dec_if;
  import sys_pkg::*;

  logic      csr_op;   // One of the six CSR instructions
  csr_fn_t   fn;
  logic      use_imm;  // Source is the zero-extended uimm
  reg_idx_t  uimm;
  logic      src_zero; // rs1 field or uimm is zero
  csr_addr_t addr;
  reg_idx_t  rd;
  logic      ecall;
  logic      mret;

  modport producer (
    output csr_op, fn, use_imm, uimm, src_zero, addr, rd, ecall, mret
  );

  modport consumer (
    input csr_op, fn, use_imm, uimm, src_zero, addr, rd, ecall, mret
  );

endinterface

// File: design/sys_pkg.sv
`include "sys_macros.svh"

package sys_pkg;

  // Architectural data word that also holds pc values
  typedef logic [`SYS_XLEN-1:0] word_t;

  // CSR address as found in instr[31:20]
  typedef logic [`SYS_CSR_AW-1:0] csr_addr_t;

  // Register index that also fits the 5-bit immediate of CSRRxI
  typedef logic [4:0] reg_idx_t;

  // funct3[1:0] of a CSR instruction where 1 is write, 2 is set and 3 is clear
  typedef logic [1:0] csr_fn_t;

endpackage

// File: design/sys_macros.svh
`ifndef SYS_MACROS_SVH
`define SYS_MACROS_SVH

// RV32 fixes the data and CSR address widths
`define SYS_XLEN   32
`define SYS_CSR_AW 12

// Machine CSR addresses
`define SYS_CSR_MSTATUS   12'h300
`define SYS_CSR_MTVEC     12'h305
`define SYS_CSR_MEPC      12'h341
`define SYS_CSR_MCAUSE    12'h342
`define SYS_CSR_MVENDORID 12'hF11
`define SYS_CSR_MARCHID   12'hF12

// Interrupt enable bits inside mstatus
`define SYS_MSTATUS_MIE_IDX  3
`define SYS_MSTATUS_MPIE_IDX 7

// Read-only identification values
`define SYS_MVENDORID_VAL 32'h5359_5355
`define SYS_MARCHID_VAL   32'h0000_0021

// Environment call from machine mode
`define SYS_CAUSE_ECALL_M 32'd11

`endif
